/* axi2avmm.f */
hdl/axi2avmm_pkg.sv
hdl/mem_req_if.sv
hdl/axi_wr_path.sv
hdl/axi_rd_path.sv
hdl/avmm_issue.sv
hdl/axi2avmm_bridge.sv
dv/tb_clk_gen.sv
dv/tb_axi2avmm.sv

/* run.sh */
#!/usr/bin/env bash
# build the bridge and its testbench with verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_axi2avmm \
  -f axi2avmm.f -o sim_axi2avmm > build.log 2>&1 \
  || { cat build.log; echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_axi2avmm > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

/* dv/tb_axi2avmm.sv */
`timescale 1ns/1ps

module tb_axi2avmm;

  import axi2avmm_pkg::*;

  // ====================
  // run length
  // ====================
  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 8;
  localparam int N_WR       = 80;
  localparam int N_RD       = 80;
  // reads pushed against a stalled controller
  localparam int N_BACKLOG  = RD_FIFO_ALMOST_FULL + 2;
  localparam int N_TXN      = N_WR + N_RD + N_BACKLOG;

  logic                   ip_clk;
  logic                   ip_rst_n;
  // axi manager side
  logic                   i_awvalid;
  logic [AXI_ADDR_W-1:0]  i_awaddr;
  logic [AXI_ID_W-1:0]    i_awid;
  logic                   i_wvalid;
  logic [DATA_W-1:0]      i_wdata;
  logic [BE_W-1:0]        i_wstrb;
  logic                   i_wuser_poison;
  logic                   i_arvalid;
  logic [AXI_ADDR_W-1:0]  i_araddr;
  logic [AXI_ID_W-1:0]    i_arid;
  logic                   o_awready;
  logic                   o_wready;
  logic                   o_arready;
  logic                   o_bvalid;
  logic [AXI_ID_W-1:0]    o_bid;
  logic                   o_rvalid;
  logic [AXI_ID_W-1:0]    o_rid;
  logic [DATA_W-1:0]      o_rdata;
  logic                   o_rpoison;
  // controller side
  logic                   o_avmm_write;
  logic                   o_avmm_read;
  logic [AVMM_ADDR_W-1:0] o_avmm_address;
  logic [DATA_W-1:0]      o_avmm_writedata;
  logic [BE_W-1:0]        o_avmm_byteenable;
  logic                   o_avmm_write_poison;
  logic                   i_avmm_ready;
  logic                   i_avmm_readdatavalid;
  logic [DATA_W-1:0]      i_avmm_readdata;
  logic                   i_avmm_read_poison;

  // scoreboard state
  int unsigned            err_cnt = 0;
  int unsigned            chk_cnt = 0;
  int unsigned            wr_acc_cnt = 0;
  int unsigned            rd_rsp_cnt = 0;
  int unsigned            stall_cnt = 0;
  int unsigned            collide_cnt = 0;
  int                     outstanding = 0;
  int                     max_outstanding = 0;
  logic                   wr_acc_prev = 1'b0;
  logic [AXI_ID_W-1:0]    wr_id_prev;
  logic [AXI_ID_W-1:0]    exp_id_q[$];
  logic [AVMM_ADDR_W-1:0] exp_addr_q[$];
  // controller model state
  logic [AVMM_ADDR_W-1:0] mdl_addr_q[$];
  longint                 mdl_due_q[$];
  longint                 cyc = 0;
  logic                   hold_rdata;

  tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) tb_clk_gen_inst (
    .o_clk   (ip_clk),
    .o_rst_n (ip_rst_n)
  );

  axi2avmm_bridge axi2avmm_bridge_inst (.*);

  // ====================
  // reference model
  // ====================

  // read data the controller returns as a fixed mix of the word address
  function automatic logic [DATA_W-1:0] exp_rdata(input logic [AVMM_ADDR_W-1:0] addr);
    logic [DATA_W-1:0] a;
    a = DATA_W'(addr);
    return (a * 64'h9E37_79B9_7F4A_7C15) ^ (a << 40) ^ 64'h0123_4567_89AB_CDEF;
  endfunction

  // 22 bit channel offset in units of 64 byte lines
  // upper bits of the word address stay zero
  function automatic logic [AVMM_ADDR_W-1:0] alias_addr(input logic [AXI_ADDR_W-1:0] addr);
    logic [AXI_ADDR_W-1:0] mask;
    mask = (32'd1 << (CHAN_ADDR_MSB - CHAN_ADDR_LSB + 1)) - 32'd1;
    return AVMM_ADDR_W'((addr >> CHAN_ADDR_LSB) & mask);
  endfunction

  task automatic check_eq(input logic [DATA_W-1:0] act, input logic [DATA_W-1:0] exp,
                          input string what);
    chk_cnt++;
    if (act !== exp)
    begin
      err_cnt++;
      $display("FAIL @%0t: %s is %0h, expected %0h", $time, what, act, exp);
    end
  endtask

  // ====================
  // compare process
  // ====================
  always @(posedge ip_clk)
  begin
    logic                   exp_wr;
    logic                   exp_rd;
    logic [AVMM_ADDR_W-1:0] rsp_addr;
    if (ip_rst_n)
    begin
      // expected handshakes with write first
      // read also gated by the id backlog
      exp_wr = i_avmm_ready && i_awvalid && i_wvalid;
      exp_rd = i_avmm_ready && i_arvalid && !exp_wr && (outstanding < RD_FIFO_ALMOST_FULL);
      check_eq(o_awready, exp_wr, "awready");
      check_eq(o_wready, exp_wr, "wready");
      check_eq(o_arready, exp_rd, "arready");
      check_eq(o_avmm_write, exp_wr, "avmm write");
      check_eq(o_avmm_read, exp_rd, "avmm read");
      if (exp_wr)
      begin
        check_eq(o_avmm_address, alias_addr(i_awaddr), "write address");
        check_eq(o_avmm_writedata, i_wdata, "write data");
        check_eq(o_avmm_byteenable, i_wstrb, "byte enable");
        check_eq(o_avmm_write_poison, i_wuser_poison, "write poison");
        wr_acc_cnt++;
        if (i_arvalid)
          collide_cnt++;
      end
      if (exp_rd)
      begin
        check_eq(o_avmm_address, alias_addr(i_araddr), "read address");
        exp_id_q.push_back(i_arid);
        exp_addr_q.push_back(alias_addr(i_araddr));
      end
      // read held off by the backlog alone
      if (i_avmm_ready && i_arvalid && !exp_wr && !exp_rd)
        stall_cnt++;
      // one response per write in the cycle after acceptance
      check_eq(o_bvalid, wr_acc_prev, "bvalid");
      if (wr_acc_prev)
        check_eq(o_bid, wr_id_prev, "bid");
      wr_acc_prev = exp_wr;
      wr_id_prev  = i_awid;
      // read response in the same cycle the controller returns data
      check_eq(o_rvalid, i_avmm_readdatavalid, "rvalid");
      if (i_avmm_readdatavalid && exp_id_q.size() == 0)
      begin
        err_cnt++;
        $display("ERROR @%0t: read data returned with no read outstanding", $time);
      end
      else if (i_avmm_readdatavalid)
      begin
        rsp_addr = exp_addr_q.pop_front();
        check_eq(o_rid, exp_id_q.pop_front(), "rid");
        check_eq(o_rdata, exp_rdata(rsp_addr), "rdata");
        check_eq(o_rpoison, rsp_addr[0], "rpoison");
        rd_rsp_cnt++;
      end
      outstanding = exp_id_q.size();
      if (outstanding > max_outstanding)
        max_outstanding = outstanding;
    end
  end

  // ====================
  // controller model
  // ====================

  // reads queue up in issue order
  // each read carries its own earliest return cycle
  always @(posedge ip_clk)
  begin
    cyc <= cyc + 1;
    if (ip_rst_n && o_avmm_read)
    begin
      mdl_addr_q.push_back(o_avmm_address);
      mdl_due_q.push_back(cyc + 1 + longint'($urandom_range(5, 0)));
    end
  end

  always @(negedge ip_clk)
  begin
    i_avmm_ready         = ($urandom_range(3, 0) != 0);
    i_avmm_readdatavalid = 1'b0;
    i_avmm_readdata      = '0;
    i_avmm_read_poison   = 1'b0;
    if (!hold_rdata && mdl_addr_q.size() != 0 && cyc >= mdl_due_q[0])
    begin
      i_avmm_readdatavalid = 1'b1;
      i_avmm_readdata      = exp_rdata(mdl_addr_q[0]);
      i_avmm_read_poison   = mdl_addr_q[0][0];
      mdl_addr_q.delete(0);
      mdl_due_q.delete(0);
    end
  end

  // ====================
  // axi manager
  // ====================
  task automatic write_txn(input int idx);
    @(negedge ip_clk);
    i_awvalid      = 1'b1;
    i_wvalid       = 1'b1;
    i_awaddr       = $urandom();
    i_awid         = AXI_ID_W'(idx);
    i_wdata        = {$urandom(), $urandom()};
    i_wstrb        = BE_W'($urandom());
    i_wuser_poison = 1'($urandom_range(1, 0));
    @(posedge ip_clk);
    while (!o_awready)
      @(posedge ip_clk);
  endtask

  task automatic read_txn(input int idx);
    @(negedge ip_clk);
    i_arvalid = 1'b1;
    i_araddr  = $urandom();
    i_arid    = AXI_ID_W'(idx);
    @(posedge ip_clk);
    while (!o_arready)
      @(posedge ip_clk);
  endtask

  initial
  begin
    void'($urandom(69473));
    {i_awvalid, i_wvalid, i_arvalid, i_wuser_poison} = '0;
    {i_awaddr, i_awid, i_wdata, i_wstrb, i_araddr, i_arid} = '0;
    {i_avmm_ready, i_avmm_readdatavalid, i_avmm_read_poison} = '0;
    i_avmm_readdata = '0;
    hold_rdata      = 1'b0;
    @(posedge ip_rst_n);
    repeat (4) @(negedge ip_clk);
    // both channels run on their own, so writes and reads often collide
    fork
      begin
        for (int i = 0; i < N_WR; i++)
        begin
          write_txn(i);
          if ($urandom_range(1, 0) == 0)
          begin
            // address phase alone must not be taken
            @(negedge ip_clk);
            i_awvalid = 1'($urandom_range(1, 0));
            i_wvalid  = 1'b0;
            repeat ($urandom_range(2, 0)) @(negedge ip_clk);
          end
        end
        @(negedge ip_clk);
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
      end
      begin
        for (int i = 0; i < N_RD; i++)
        begin
          read_txn(i);
          @(negedge ip_clk);
          i_arvalid = 1'b0;
          repeat ($urandom_range(1, 0)) @(negedge ip_clk);
        end
      end
    join
    while (outstanding != 0)
      @(negedge ip_clk);
    // read data withheld until arready has been held low by the backlog
    hold_rdata = 1'b1;
    for (int i = 0; i < RD_FIFO_ALMOST_FULL; i++)
      read_txn(N_RD + i);
    fork
      read_txn(N_RD + RD_FIFO_ALMOST_FULL);
      begin
        repeat (20) @(posedge ip_clk);
        hold_rdata = 1'b0;
      end
    join
    read_txn(N_RD + RD_FIFO_ALMOST_FULL + 1);
    @(negedge ip_clk);
    i_arvalid = 1'b0;
    while (outstanding != 0)
      @(negedge ip_clk);
    repeat (4) @(negedge ip_clk);
    check_eq(wr_acc_cnt, N_WR, "accepted writes");
    check_eq(rd_rsp_cnt, N_RD + N_BACKLOG, "read responses");
    check_eq(max_outstanding, RD_FIFO_ALMOST_FULL, "peak read backlog");
    if (stall_cnt == 0 || collide_cnt == 0)
    begin
      err_cnt++;
      $display("ERROR: backlog stall or write/read collision never happened");
    end
    $display("summary: %0d checks, %0d errors, %0d writes, %0d reads, %0d collisions",
             chk_cnt, err_cnt, wr_acc_cnt, rd_rsp_cnt, collide_cnt);
    if (err_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // watchdog allows 40 cycles per transaction on top of reset
  initial
  begin
    #((N_TXN * 40 + RST_CYCLES) * CLK_PERIOD);
    $display("ERROR: run timed out at %0t, the bridge stopped making progress", $time);
    $display("summary: %0d checks, %0d errors, %0d writes, %0d reads, %0d collisions",
             chk_cnt, err_cnt, wr_acc_cnt, rd_rsp_cnt, collide_cnt);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int CLK_PERIOD = 4,
  parameter int RST_CYCLES = 8
) (
  output logic o_clk,
  output logic o_rst_n
);

  // free running clock, starts low
  initial
  begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
  end

  // reset held over RST_CYCLES rising edges, released on a falling edge
  initial
  begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

/* hdl/axi2avmm_bridge.sv */
`timescale 1ns/1ps

module axi2avmm_bridge (
  input  logic                                 ip_clk,
  input  logic                                 ip_rst_n,

  // axi write address and data
  input  logic                                 i_awvalid,
  input  logic [axi2avmm_pkg::AXI_ADDR_W-1:0]  i_awaddr,
  input  logic [axi2avmm_pkg::AXI_ID_W-1:0]    i_awid,
  output logic                                 o_awready,
  input  logic                                 i_wvalid,
  input  logic [axi2avmm_pkg::DATA_W-1:0]      i_wdata,
  input  logic [axi2avmm_pkg::BE_W-1:0]        i_wstrb,
  input  logic                                 i_wuser_poison,
  output logic                                 o_wready,

  // axi write response, always okay
  output logic                                 o_bvalid,
  output logic [axi2avmm_pkg::AXI_ID_W-1:0]    o_bid,

  // axi read address
  input  logic                                 i_arvalid,
  input  logic [axi2avmm_pkg::AXI_ADDR_W-1:0]  i_araddr,
  input  logic [axi2avmm_pkg::AXI_ID_W-1:0]    i_arid,
  output logic                                 o_arready,

  // axi read response, single beat
  output logic                                 o_rvalid,
  output logic [axi2avmm_pkg::AXI_ID_W-1:0]    o_rid,
  output logic [axi2avmm_pkg::DATA_W-1:0]      o_rdata,
  output logic                                 o_rpoison,

  // avmm request to the memory controller
  output logic                                 o_avmm_write,
  output logic                                 o_avmm_read,
  output logic [axi2avmm_pkg::AVMM_ADDR_W-1:0] o_avmm_address,
  output logic [axi2avmm_pkg::DATA_W-1:0]      o_avmm_writedata,
  output logic [axi2avmm_pkg::BE_W-1:0]        o_avmm_byteenable,
  output logic                                 o_avmm_write_poison,
  input  logic                                 i_avmm_ready,

  // avmm read return
  input  logic                                 i_avmm_readdatavalid,
  input  logic [axi2avmm_pkg::DATA_W-1:0]      i_avmm_readdata,
  input  logic                                 i_avmm_read_poison
);

  // one request bundle per path
  mem_req_if wr_req ();
  mem_req_if rd_req ();

  // ====================
  // axi ready
  // ====================

  // aw and w are accepted together
  assign o_awready = wr_req.grant;
  assign o_wready  = wr_req.grant;
  assign o_arready = rd_req.grant;

  axi_wr_path axi_wr_path_inst (
    .ip_clk         (ip_clk),
    .ip_rst_n       (ip_rst_n),
    .i_awvalid      (i_awvalid),
    .i_wvalid       (i_wvalid),
    .i_awaddr       (i_awaddr),
    .i_awid         (i_awid),
    .i_wdata        (i_wdata),
    .i_wstrb        (i_wstrb),
    .i_wuser_poison (i_wuser_poison),
    .wr_req         (wr_req.path),
    .o_bvalid       (o_bvalid),
    .o_bid          (o_bid)
  );

  axi_rd_path axi_rd_path_inst (
    .ip_clk               (ip_clk),
    .ip_rst_n             (ip_rst_n),
    .i_arvalid            (i_arvalid),
    .i_araddr             (i_araddr),
    .i_arid               (i_arid),
    .i_avmm_readdatavalid (i_avmm_readdatavalid),
    .i_avmm_readdata      (i_avmm_readdata),
    .i_avmm_read_poison   (i_avmm_read_poison),
    .rd_req               (rd_req.path),
    .o_rvalid             (o_rvalid),
    .o_rid                (o_rid),
    .o_rdata              (o_rdata),
    .o_rpoison            (o_rpoison)
  );

  avmm_issue avmm_issue_inst (
    .ip_clk              (ip_clk),
    .ip_rst_n            (ip_rst_n),
    .i_avmm_ready        (i_avmm_ready),
    .wr_req              (wr_req.arbiter),
    .rd_req              (rd_req.arbiter),
    .o_avmm_write        (o_avmm_write),
    .o_avmm_read         (o_avmm_read),
    .o_avmm_address      (o_avmm_address),
    .o_avmm_writedata    (o_avmm_writedata),
    .o_avmm_byteenable   (o_avmm_byteenable),
    .o_avmm_write_poison (o_avmm_write_poison)
  );

endmodule

/* hdl/avmm_issue.sv */
`timescale 1ns/1ps

module avmm_issue (
  input  logic                                 ip_clk,
  input  logic                                 ip_rst_n,
  input  logic                                 i_avmm_ready,
  mem_req_if.arbiter                           wr_req,
  mem_req_if.arbiter                           rd_req,
  output logic                                 o_avmm_write,
  output logic                                 o_avmm_read,
  output logic [axi2avmm_pkg::AVMM_ADDR_W-1:0] o_avmm_address,
  output logic [axi2avmm_pkg::DATA_W-1:0]      o_avmm_writedata,
  output logic [axi2avmm_pkg::BE_W-1:0]        o_avmm_byteenable,
  output logic                                 o_avmm_write_poison
);

  import axi2avmm_pkg::*;

  avmm_op_e op;
  // set one cycle after reset release
  logic     issue_en_q;

  always_ff @(posedge ip_clk)
  begin
    if (!ip_rst_n)
      issue_en_q <= 1'b0;
    else
      issue_en_q <= 1'b1;
  end

  // ====================
  // arbitration
  // ====================

  // write has fixed priority over read
  always_comb
  begin
    op = OP_IDLE;
    if (issue_en_q && i_avmm_ready)
    begin
      if (wr_req.req_valid)
        op = OP_WRITE;
      else if (rd_req.req_valid)
        op = OP_READ;
    end
  end

  // a grant is the completed axi handshake
  assign wr_req.grant = (op == OP_WRITE);
  assign rd_req.grant = (op == OP_READ);

  // ====================
  // avmm request mux
  // ====================

  always_comb
  begin
    // zero when idle
    o_avmm_write        = 1'b0;
    o_avmm_read         = 1'b0;
    o_avmm_address      = '0;
    o_avmm_writedata    = '0;
    o_avmm_byteenable   = '0;
    o_avmm_write_poison = 1'b0;
    case (op)
      OP_WRITE:
      begin
        o_avmm_write        = 1'b1;
        o_avmm_address      = wr_req.address;
        o_avmm_writedata    = wr_req.data;
        o_avmm_byteenable   = wr_req.byte_enable;
        o_avmm_write_poison = wr_req.poison;
      end
      OP_READ:
      begin
        o_avmm_read         = 1'b1;
        o_avmm_address      = rd_req.address;
        // read path drives zero payload
        o_avmm_writedata    = rd_req.data;
        o_avmm_byteenable   = rd_req.byte_enable;
        o_avmm_write_poison = rd_req.poison;
      end
      default:
      begin
        o_avmm_write = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/axi_rd_path.sv */
`timescale 1ns/1ps

module axi_rd_path (
  input  logic                                ip_clk,
  input  logic                                ip_rst_n,
  input  logic                                i_arvalid,
  input  logic [axi2avmm_pkg::AXI_ADDR_W-1:0] i_araddr,
  input  logic [axi2avmm_pkg::AXI_ID_W-1:0]   i_arid,
  input  logic                                i_avmm_readdatavalid,
  input  logic [axi2avmm_pkg::DATA_W-1:0]     i_avmm_readdata,
  input  logic                                i_avmm_read_poison,
  mem_req_if.path                             rd_req,
  output logic                                o_rvalid,
  output logic [axi2avmm_pkg::AXI_ID_W-1:0]   o_rid,
  output logic [axi2avmm_pkg::DATA_W-1:0]     o_rdata,
  output logic                                o_rpoison
);

  import axi2avmm_pkg::*;

  // read-id fifo, show-ahead
  logic [AXI_ID_W-1:0]              id_mem [RD_FIFO_DEPTH];
  logic [$clog2(RD_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(RD_FIFO_DEPTH)-1:0] rd_ptr;
  // one bit wider than the pointers, counts up to full
  logic [$clog2(RD_FIFO_DEPTH):0]   fill;
  logic                             push;
  logic                             pop;

  // ====================
  // request forming
  // ====================

  // hold off new reads while the id fifo is nearly full
  assign rd_req.req_valid   = i_arvalid && (fill < RD_FIFO_ALMOST_FULL);
  assign rd_req.address     = AVMM_ADDR_W'(i_araddr[CHAN_ADDR_MSB:CHAN_ADDR_LSB]);
  // reads carry no payload
  assign rd_req.data        = '0;
  assign rd_req.byte_enable = '0;
  assign rd_req.poison      = 1'b0;
  assign rd_req.id          = i_arid;

  // ====================
  // id fifo
  // ====================

  // push on issue, pop on returned data
  assign push = rd_req.grant;
  // ignore readdatavalid with nothing outstanding
  assign pop  = i_avmm_readdatavalid && (fill != '0);

  always_ff @(posedge ip_clk)
  begin
    if (!ip_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leaves the level unchanged
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // id storage
  always_ff @(posedge ip_clk)
  begin
    if (push)
      id_mem[wr_ptr] <= rd_req.id;
  end

  // ====================
  // read response
  // ====================

  // reads return in order, oldest id sits at the head
  assign o_rvalid  = i_avmm_readdatavalid;
  assign o_rid     = id_mem[rd_ptr];
  assign o_rdata   = i_avmm_readdata;
  assign o_rpoison = i_avmm_read_poison;

endmodule

/* hdl/axi_wr_path.sv */
`timescale 1ns/1ps

module axi_wr_path (
  input  logic                             ip_clk,
  input  logic                             ip_rst_n,
  input  logic                             i_awvalid,
  input  logic                             i_wvalid,
  input  logic [axi2avmm_pkg::AXI_ADDR_W-1:0] i_awaddr,
  input  logic [axi2avmm_pkg::AXI_ID_W-1:0]   i_awid,
  input  logic [axi2avmm_pkg::DATA_W-1:0]     i_wdata,
  input  logic [axi2avmm_pkg::BE_W-1:0]       i_wstrb,
  input  logic                             i_wuser_poison,
  mem_req_if.path                          wr_req,
  output logic                             o_bvalid,
  output logic [axi2avmm_pkg::AXI_ID_W-1:0]   o_bid
);

  import axi2avmm_pkg::*;

  // staged write response
  logic                bvalid_q;
  logic [AXI_ID_W-1:0] bid_q;

  // ====================
  // request forming
  // ====================

  // address and data phases must line up in one cycle
  assign wr_req.req_valid   = i_awvalid & i_wvalid;
  // channel address alias, upper bits forced to zero
  assign wr_req.address     = AVMM_ADDR_W'(i_awaddr[CHAN_ADDR_MSB:CHAN_ADDR_LSB]);
  assign wr_req.data        = i_wdata;
  assign wr_req.byte_enable = i_wstrb;
  assign wr_req.poison      = i_wuser_poison;
  assign wr_req.id          = i_awid;

  // ====================
  // write response
  // ====================

  // response goes back one cycle after the grant
  // the controller is not waited on
  always_ff @(posedge ip_clk)
  begin
    if (!ip_rst_n)
      bvalid_q <= 1'b0;
    else
      bvalid_q <= wr_req.grant;
  end

  // id of the granted write, held for the response
  always_ff @(posedge ip_clk)
  begin
    if (wr_req.grant)
      bid_q <= wr_req.id;
  end

  assign o_bvalid = bvalid_q;
  assign o_bid    = bid_q;

endmodule

/* hdl/mem_req_if.sv */
`timescale 1ns/1ps

// one request path towards the issue arbiter
interface mem_req_if;

  import axi2avmm_pkg::*;

  // request side, driven by a write or read path
  logic                   req_valid;
  logic [AVMM_ADDR_W-1:0] address;
  logic [DATA_W-1:0]      data;
  logic [BE_W-1:0]        byte_enable;
  logic                   poison;
  logic [AXI_ID_W-1:0]    id;

  // high in the cycle the request goes out on avmm
  logic grant;

  // request path side
  modport path (
    output req_valid, address, data, byte_enable, poison, id,
    input  grant
  );

  // issue arbiter side
  modport arbiter (
    input  req_valid, address, data, byte_enable, poison, id,
    output grant
  );

endinterface

/* hdl/axi2avmm_pkg.sv */
package axi2avmm_pkg;

  // ====================
  // bus widths
  // ====================

  // axi side
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_ID_W   = 8;

  // data path, one byte enable per byte
  localparam int DATA_W = 64;
  localparam int BE_W   = DATA_W / 8;

  // channel address slice of the axi address
  // the slice is zero-extended to the avmm word address
  localparam int CHAN_ADDR_MSB = 27;
  localparam int CHAN_ADDR_LSB = 6;
  localparam int AVMM_ADDR_W   = 26;

  // ====================
  // read-id fifo
  // ====================
  localparam int RD_FIFO_DEPTH       = 16;
  // arready drops at this fill level
  localparam int RD_FIFO_ALMOST_FULL = 14;

  // operation put on the avmm port in one cycle
  typedef enum logic [1:0] {OP_IDLE = 2'd0, OP_WRITE = 2'd1, OP_READ = 2'd2} avmm_op_e;

endpackage
